/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_muldiv
RTL_TOP    ?= muldiv_top
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= 1ns/100ps
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall

PASS_MSG := *** TEST PASSED ***
FAIL_MSG := *** TEST FAILED ***

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter source/%,$(SRCS))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) --top-module $(RTL_TOP) $(RTL_SRCS)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "no pass message in $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* source/muldiv_pkg.sv */
package muldiv_pkg;

	// command encoding in ctrl bits 2..1
	typedef enum logic [1:0] {
		op_mul_pair     = 2'd0,
		op_mul_wide     = 2'd1,
		op_div_unsigned = 2'd2,
		op_div_signed   = 2'd3
	} op_t;

	// operands and results are 64 bits wide
	localparam int operand_width = 64;

	// the multiplier works on 16-bit slices of each operand
	localparam int slice_width = 16;
	localparam int slice_count = operand_width / slice_width;

endpackage

/* source/muldiv_regs.sv */
module muldiv_regs
	import muldiv_pkg::*;
	import muldiv_regs_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,

	input  logic [addr_width-1:0]    awaddr,
	input  logic                     awvalid,
	output logic                     awready,
	input  logic [31:0]              wdata,
	input  logic                     wvalid,
	output logic                     wready,
	output logic [1:0]               bresp,
	output logic                     bvalid,
	input  logic                     bready,

	input  logic [addr_width-1:0]    araddr,
	input  logic                     arvalid,
	output logic                     arready,
	output logic [31:0]              rdata,
	output logic [1:0]               rresp,
	output logic                     rvalid,
	input  logic                     rready,

	output logic                     mul_start,
	output logic                     mul_wide,
	output logic                     div_start,
	output logic                     div_signed,
	input  logic                     mul_ready,
	input  logic                     mul_done,
	input  logic                     div_ready,
	input  logic                     div_done,
	output logic [operand_width-1:0] a,
	output logic [operand_width-1:0] b,
	input  logic [operand_width-1:0] mul_result,
	input  logic [operand_width-1:0] div_quot,
	input  logic [operand_width-1:0] div_rem
);

	logic [operand_width-1:0] r0;
	logic [operand_width-1:0] r1;
	op_t                      op_q;
	op_t                      cmd_op;
	logic                     busy;
	logic                     done;
	logic                     div_by_zero;
	logic                     wr_hs;
	logic                     rd_hs;
	logic                     cmd_go;
	logic                     cmd_div;
	logic                     cmd_dbz;
	logic                     cmd_accept;
	logic                     sel_ready;
	logic [1:0]               wr_resp;
	logic [1:0]               rd_resp;
	logic [31:0]              rd_word;

	assign wr_hs = awvalid && awready && wvalid && wready;
	assign rd_hs = arvalid && arready;

	// command decode straight from the ctrl write
	assign cmd_op = op_t'(wdata[ctrl_op_msb:ctrl_op_lsb]);
	assign cmd_div = (cmd_op == op_div_unsigned) || (cmd_op == op_div_signed);
	assign sel_ready = cmd_div ? div_ready : mul_ready;
	assign cmd_go = wr_hs && (awaddr == reg_ctrl) && wdata[ctrl_start_bit] && !busy;
	assign cmd_dbz = cmd_go && cmd_div && (b == '0);
	assign cmd_accept = cmd_go && !cmd_dbz && sel_ready;

	assign mul_wide = (op_q == op_mul_wide);
	assign div_signed = (op_q == op_div_signed);

	always_comb
	begin
		case (awaddr)
			reg_ctrl, reg_a_lo, reg_a_hi, reg_b_lo, reg_b_hi: wr_resp = resp_okay;
			default: wr_resp = resp_slverr;
		endcase
	end

	always_comb
	begin
		rd_word = '0;
		rd_resp = resp_okay;
		case (araddr)
			reg_ctrl: rd_word[ctrl_op_msb:ctrl_op_lsb] = op_q;
			reg_status:
			begin
				rd_word[status_busy_bit] = busy;
				rd_word[status_done_bit] = done;
				rd_word[status_dbz_bit] = div_by_zero;
			end
			reg_a_lo:  rd_word = a[31:0];
			reg_a_hi:  rd_word = a[63:32];
			reg_b_lo:  rd_word = b[31:0];
			reg_b_hi:  rd_word = b[63:32];
			reg_r0_lo: rd_word = r0[31:0];
			reg_r0_hi: rd_word = r0[63:32];
			reg_r1_lo: rd_word = r1[31:0];
			reg_r1_hi: rd_word = r1[63:32];
			default:   rd_resp = resp_slverr;
		endcase
	end

	// at most one write and one read in flight
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			arready <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (wr_hs)
			begin
				awready <= 1'b0;
				wready <= 1'b0;
				bvalid <= 1'b1;
			end
			else if (awvalid && wvalid && !awready && !bvalid)
			begin
				awready <= 1'b1;
				wready <= 1'b1;
			end

			if (rvalid && rready)
				rvalid <= 1'b0;
			if (rd_hs)
			begin
				arready <= 1'b0;
				rvalid <= 1'b1;
			end
			else if (arvalid && !arready && !rvalid)
				arready <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_hs)
			bresp <= wr_resp;
		if (rd_hs)
		begin
			rdata <= rd_word;
			rresp <= rd_resp;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_hs)
		begin
			case (awaddr)
				reg_a_lo: a[31:0] <= wdata;
				reg_a_hi: a[63:32] <= wdata;
				reg_b_lo: b[31:0] <= wdata;
				reg_b_hi: b[63:32] <= wdata;
				default: ;
			endcase
		end
	end

	// divide by zero fills the results without the divider
	always_ff @(posedge clk)
	begin
		if (cmd_dbz)
		begin
			r0 <= '1;
			r1 <= a;
		end
		else if (mul_done)
			r0 <= mul_result;
		else if (div_done)
		begin
			r0 <= div_quot;
			r1 <= div_rem;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			op_q <= op_mul_pair;
			mul_start <= 1'b0;
			div_start <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			div_by_zero <= 1'b0;
		end
		else
		begin
			mul_start <= cmd_accept && !cmd_div;
			div_start <= cmd_accept && cmd_div;
			if (cmd_accept || cmd_dbz)
				op_q <= cmd_op;

			if (cmd_dbz)
			begin
				done <= 1'b1;
				div_by_zero <= 1'b1;
			end
			else if (cmd_accept)
			begin
				busy <= 1'b1;
				done <= 1'b0;
				div_by_zero <= 1'b0;
			end
			else if (busy && (mul_done || div_done))
			begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) mul_start |-> mul_ready)
		else $error("muldiv_regs: multiplier started while not ready");

	assert property (@(posedge clk) disable iff (!rst_n) div_start |-> div_ready)
		else $error("muldiv_regs: divider started while not ready");

	assert property (@(posedge clk) disable iff (!rst_n) bvalid && !bready |=> bvalid)
		else $error("muldiv_regs: bvalid dropped before bready");

endmodule

/* source/muldiv_regs_pkg.sv */
package muldiv_regs_pkg;

	localparam int addr_width = 8;

	// AXI response codes
	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// byte offsets of the 32-bit registers
	localparam logic [addr_width-1:0] reg_ctrl   = 8'h00;
	localparam logic [addr_width-1:0] reg_status = 8'h04;
	localparam logic [addr_width-1:0] reg_a_lo   = 8'h08;
	localparam logic [addr_width-1:0] reg_a_hi   = 8'h0C;
	localparam logic [addr_width-1:0] reg_b_lo   = 8'h10;
	localparam logic [addr_width-1:0] reg_b_hi   = 8'h14;
	localparam logic [addr_width-1:0] reg_r0_lo  = 8'h18;
	localparam logic [addr_width-1:0] reg_r0_hi  = 8'h1C;
	localparam logic [addr_width-1:0] reg_r1_lo  = 8'h20;
	localparam logic [addr_width-1:0] reg_r1_hi  = 8'h24;

	// ctrl fields
	localparam int ctrl_start_bit = 0;
	localparam int ctrl_op_lsb    = 1;
	localparam int ctrl_op_msb    = 2;

	// status fields
	localparam int status_busy_bit = 0;
	localparam int status_done_bit = 1;
	localparam int status_dbz_bit  = 2;

endpackage

/* source/muldiv_top.sv */
module muldiv_top
	import muldiv_pkg::*;
	import muldiv_regs_pkg::*;
#(
	parameter int div_width = operand_width
) (
	input  logic                  clk,
	input  logic                  rst_n,

	input  logic [addr_width-1:0] awaddr,
	input  logic                  awvalid,
	output logic                  awready,
	input  logic [31:0]           wdata,
	input  logic                  wvalid,
	output logic                  wready,
	output logic [1:0]            bresp,
	output logic                  bvalid,
	input  logic                  bready,

	input  logic [addr_width-1:0] araddr,
	input  logic                  arvalid,
	output logic                  arready,
	output logic [31:0]           rdata,
	output logic [1:0]            rresp,
	output logic                  rvalid,
	input  logic                  rready
);

	logic                     mul_start;
	logic                     mul_wide;
	logic                     mul_ready;
	logic                     mul_done;
	logic [operand_width-1:0] mul_result;
	logic                     div_start;
	logic                     div_signed;
	logic                     div_ready;
	logic                     div_done;
	logic [div_width-1:0]     div_quot;
	logic [div_width-1:0]     div_rem;
	logic [operand_width-1:0] a;
	logic [operand_width-1:0] b;

	muldiv_regs i_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.awaddr     (awaddr),
		.awvalid    (awvalid),
		.awready    (awready),
		.wdata      (wdata),
		.wvalid     (wvalid),
		.wready     (wready),
		.bresp      (bresp),
		.bvalid     (bvalid),
		.bready     (bready),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rresp      (rresp),
		.rvalid     (rvalid),
		.rready     (rready),
		.mul_start  (mul_start),
		.mul_wide   (mul_wide),
		.div_start  (div_start),
		.div_signed (div_signed),
		.mul_ready  (mul_ready),
		.mul_done   (mul_done),
		.div_ready  (div_ready),
		.div_done   (div_done),
		.a          (a),
		.b          (b),
		.mul_result (mul_result),
		.div_quot   (div_quot),
		.div_rem    (div_rem)
	);

	sliced_mul i_mul (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (mul_start),
		.wide   (mul_wide),
		.a      (a),
		.b      (b),
		.ready  (mul_ready),
		.done   (mul_done),
		.result (mul_result)
	);

	nonrestoring_div #(
		.width (div_width)
	) i_div (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (div_start),
		.signed_mode (div_signed),
		.num         (a),
		.denom       (b),
		.ready       (div_ready),
		.done        (div_done),
		.quot        (div_quot),
		.rem         (div_rem)
	);

endmodule

/* source/nonrestoring_div.sv */
module nonrestoring_div #(
	parameter int width = 64
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             start,
	input  logic             signed_mode,
	input  logic [width-1:0] num,
	input  logic [width-1:0] denom,
	output logic             ready,
	output logic             done,
	output logic [width-1:0] quot,
	output logic [width-1:0] rem
);

	// partial remainder is double width plus a sign bit
	localparam int pr_width    = 2 * width + 1;
	localparam int count_width = $clog2(width);

	typedef enum logic [2:0] {
		st_idle,
		st_abs,
		st_iter,
		st_fix,
		st_finish
	} state_t;

	state_t state;

	logic [count_width-1:0] count;
	logic [width-1:0]       num_q;
	logic [width-1:0]       denom_q;
	logic                   num_neg;
	logic                   denom_neg;
	logic [width-1:0]       num_mag;
	logic [width-1:0]       denom_mag;
	logic [pr_width-1:0]    p;
	logic [pr_width-1:0]    d;
	logic [pr_width-1:0]    p_next;
	logic [pr_width-1:0]    p_fixed;
	logic [width-1:0]       q;
	logic [width-1:0]       q_conv;
	logic [width-1:0]       q_mag;
	logic [width-1:0]       r_mag;

	assign ready = (state == st_idle);

	always_comb
	begin
		num_mag = num_neg ? -num_q : num_q;
		denom_mag = denom_neg ? -denom_q : denom_q;

		// negative remainder adds the divisor back, else subtract it
		p_next = p[pr_width-1] ? (p << 1) + d : (p << 1) - d;

		// digits are +1/-1 encoded as 1/0
		q_conv = q - ~q;
		q_mag = q_conv - {{(width-1){1'b0}}, p[pr_width-1]};
		p_fixed = p[pr_width-1] ? p + d : p;
		r_mag = p_fixed[2*width-1:width];
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= st_idle;
			count <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				st_idle:
				begin
					if (start)
						state <= st_abs;
				end
				st_abs:
				begin
					state <= st_iter;
					count <= count_width'(width - 1);
				end
				st_iter:
				begin
					if (count == '0)
						state <= st_fix;
					count <= count - 1'b1;
				end
				st_fix: state <= st_finish;
				default:
				begin
					done <= 1'b1;
					state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		case (state)
			st_idle:
			begin
				if (start)
				begin
					num_q <= num;
					denom_q <= denom;
					num_neg <= signed_mode && num[width-1];
					denom_neg <= signed_mode && denom[width-1];
				end
			end
			st_abs:
			begin
				p <= {{(width+1){1'b0}}, num_mag};
				d <= {1'b0, denom_mag, {width{1'b0}}};
			end
			st_iter:
			begin
				p <= p_next;
				q <= {q[width-2:0], ~p[pr_width-1]};
			end
			st_fix:
			begin
				// truncate toward zero, remainder follows the numerator
				quot <= (num_neg ^ denom_neg) ? -q_mag : q_mag;
				rem <= num_neg ? -r_mag : r_mag;
			end
			default: ;
		endcase
	end

	assert property (@(posedge clk) disable iff (!rst_n) !ready |-> !start)
		else $error("nonrestoring_div: start while busy");

endmodule

/* source/sliced_mul.sv */
module sliced_mul
	import muldiv_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     start,
	input  logic                     wide,
	input  logic [operand_width-1:0] a,
	input  logic [operand_width-1:0] b,
	output logic                     ready,
	output logic                     done,
	output logic [operand_width-1:0] result
);

	localparam int prod_width  = 2 * slice_width;
	localparam int half_slices = slice_count / 2;

	typedef logic [operand_width-1:0] word_t;

	typedef enum logic [2:0] {
		st_idle,
		st_pair_add,
		st_wide_add0,
		st_wide_add1,
		st_wide_add2,
		st_wide_add3,
		st_finish
	} state_t;

	state_t state;

	logic [slice_width-1:0] a_sl [slice_count];
	logic [slice_width-1:0] b_sl [slice_count];
	logic [prod_width-1:0]  pp [slice_count][slice_count];

	// partial sums grouped by weight and already shifted into place
	word_t part1;
	word_t part2;
	word_t part3;

	// in pair mode a product only matters inside its own 32-bit half,
	// and two upper slices would land above bit 31
	function automatic logic pair_slice(input int i, input int j);
		return (i / half_slices == j / half_slices)
			&& ((i % half_slices) + (j % half_slices) < half_slices);
	endfunction

	assign ready = (state == st_idle);

	always_comb
	begin
		for (int i = 0; i < slice_count; i++)
		begin
			a_sl[i] = a[i*slice_width +: slice_width];
			b_sl[i] = b[i*slice_width +: slice_width];
		end
	end

	// wide mode needs only the products below bit 64
	always_ff @(posedge clk)
	begin
		if (start && ready)
		begin
			for (int i = 0; i < slice_count; i++)
			begin
				for (int j = 0; j < slice_count; j++)
				begin
					if (wide ? (i + j < slice_count) : pair_slice(i, j))
						pp[i][j] <= a_sl[i] * b_sl[j];
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= st_idle;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				st_idle:
				begin
					if (start)
						state <= wide ? st_wide_add0 : st_pair_add;
				end
				st_pair_add:  state <= st_finish;
				st_wide_add0: state <= st_wide_add1;
				st_wide_add1: state <= st_wide_add2;
				st_wide_add2: state <= st_wide_add3;
				st_wide_add3: state <= st_finish;
				default:
				begin
					done <= 1'b1;
					state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		case (state)
			st_pair_add:
			begin
				// cross terms only reach the upper 16 bits of each half
				result[prod_width-1:0] <= pp[0][0]
					+ {pp[1][0][slice_width-1:0] + pp[0][1][slice_width-1:0],
					{slice_width{1'b0}}};
				result[operand_width-1:prod_width] <= pp[2][2]
					+ {pp[3][2][slice_width-1:0] + pp[2][3][slice_width-1:0],
					{slice_width{1'b0}}};
			end
			st_wide_add0:
			begin
				result <= word_t'(pp[0][0]);
				part1 <= (word_t'(pp[1][0]) + word_t'(pp[0][1])) << slice_width;
				part2 <= (word_t'(pp[2][0]) + word_t'(pp[1][1])) << (2 * slice_width);
				part3 <= (word_t'(pp[3][0]) + word_t'(pp[2][1])) << (3 * slice_width);
			end
			st_wide_add1:
			begin
				result <= result + part1;
				part2 <= part2 + (word_t'(pp[0][2]) << (2 * slice_width));
				part3 <= part3 + (word_t'(pp[1][2]) << (3 * slice_width));
			end
			st_wide_add2:
			begin
				result <= result + part2;
				part3 <= part3 + (word_t'(pp[0][3]) << (3 * slice_width));
			end
			st_wide_add3: result <= result + part3;
			default: ;
		endcase
	end

	assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else $error("sliced_mul: done longer than one cycle");

	assert property (@(posedge clk) disable iff (!rst_n) start |-> ready)
		else $error("sliced_mul: start while not ready");

endmodule

/* tb.f */
source/muldiv_pkg.sv
source/muldiv_regs_pkg.sv
source/sliced_mul.sv
source/nonrestoring_div.sv
source/muldiv_regs.sv
source/muldiv_top.sv
tb/tb_muldiv.sv

/* tb/tb_muldiv.sv */
module tb_muldiv
	import muldiv_pkg::*;
	import muldiv_regs_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	// cycles allowed for one handshake, polls allowed for one command
	localparam int hs_timeout   = 64;
	localparam int poll_timeout = 100;

	localparam logic [31:0] done_word = 32'h1 << status_done_bit;
	localparam logic [31:0] busy_word = 32'h1 << status_busy_bit;
	localparam logic [31:0] dbz_word  = done_word | (32'h1 << status_dbz_bit);
	localparam logic [63:0] all_ones  = 64'hFFFF_FFFF_FFFF_FFFF;

	logic                  clk;
	logic                  rst_n;
	logic [addr_width-1:0] awaddr;
	logic                  awvalid;
	logic                  awready;
	logic [31:0]           wdata;
	logic                  wvalid;
	logic                  wready;
	logic [1:0]            bresp;
	logic                  bvalid;
	logic                  bready;
	logic [addr_width-1:0] araddr;
	logic                  arvalid;
	logic                  arready;
	logic [31:0]           rdata;
	logic [1:0]            rresp;
	logic                  rvalid;
	logic                  rready;

	logic [31:0] rng_state;

	muldiv_top i_dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_word();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic logic [63:0] rand64();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = next_word();
		lo = next_word();
		return {hi, lo};
	endfunction

	task automatic abort_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	// outputs are sampled on the falling edge, inputs change on the rising edge
	task automatic axi_write(input logic [addr_width-1:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int cycles;
		@(posedge clk);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wvalid <= 1'b1;
		cycles = 0;
		@(negedge clk);
		while (!(awready && wready))
		begin
			cycles++;
			if (cycles > hs_timeout)
			begin
				$display("timeout: write to offset %h was never accepted", addr);
				abort_run();
			end
			@(negedge clk);
		end
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		bready <= 1'b1;
		cycles = 0;
		@(negedge clk);
		while (!bvalid)
		begin
			cycles++;
			if (cycles > hs_timeout)
			begin
				$display("timeout: no write response for offset %h", addr);
				abort_run();
			end
			@(negedge clk);
		end
		resp = bresp;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [addr_width-1:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int cycles;
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		cycles = 0;
		@(negedge clk);
		while (!arready)
		begin
			cycles++;
			if (cycles > hs_timeout)
			begin
				$display("timeout: read of offset %h was never accepted", addr);
				abort_run();
			end
			@(negedge clk);
		end
		@(posedge clk);
		arvalid <= 1'b0;
		rready <= 1'b1;
		cycles = 0;
		@(negedge clk);
		while (!rvalid)
		begin
			cycles++;
			if (cycles > hs_timeout)
			begin
				$display("timeout: no read data for offset %h", addr);
				abort_run();
			end
			@(negedge clk);
		end
		data = rdata;
		resp = rresp;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic write_reg(input logic [addr_width-1:0] addr, input logic [31:0] data);
		logic [1:0] resp;
		axi_write(addr, data, resp);
		check("bresp", 64'(resp), 64'(resp_okay));
	endtask

	task automatic read_reg(input logic [addr_width-1:0] addr, output logic [31:0] data);
		logic [1:0] resp;
		axi_read(addr, data, resp);
		check("rresp", 64'(resp), 64'(resp_okay));
	endtask

	function automatic logic [31:0] ctrl_word(input op_t op);
		logic [31:0] w;
		w = '0;
		w[ctrl_start_bit] = 1'b1;
		w[ctrl_op_msb:ctrl_op_lsb] = op;
		return w;
	endfunction

	task automatic start_op(input op_t op, input logic [63:0] a, input logic [63:0] b);
		write_reg(reg_a_lo, a[31:0]);
		write_reg(reg_a_hi, a[63:32]);
		write_reg(reg_b_lo, b[31:0]);
		write_reg(reg_b_hi, b[63:32]);
		write_reg(reg_ctrl, ctrl_word(op));
	endtask

	task automatic wait_done(output logic [31:0] status);
		int polls;
		logic [31:0] word;
		polls = 0;
		read_reg(reg_status, word);
		while (!word[status_done_bit])
		begin
			polls++;
			if (polls > poll_timeout)
			begin
				$display("timeout: done never showed up in the status register");
				abort_run();
			end
			read_reg(reg_status, word);
		end
		status = word;
	endtask

	task automatic read_results(output logic [63:0] r0, output logic [63:0] r1);
		logic [31:0] lo;
		logic [31:0] hi;
		read_reg(reg_r0_lo, lo);
		read_reg(reg_r0_hi, hi);
		r0 = {hi, lo};
		read_reg(reg_r1_lo, lo);
		read_reg(reg_r1_hi, hi);
		r1 = {hi, lo};
	endtask

	task automatic run_op(input op_t op, input logic [63:0] a, input logic [63:0] b,
		output logic [63:0] r0, output logic [63:0] r1, output logic [31:0] status);
		start_op(op, a, b);
		wait_done(status);
		read_results(r0, r1);
	endtask

	task automatic pair_case(input logic [63:0] a, input logic [63:0] b);
		logic [63:0] r0;
		logic [63:0] r1;
		logic [31:0] status;
		logic [31:0] exp_lo;
		logic [31:0] exp_hi;
		exp_lo = a[31:0] * b[31:0];
		exp_hi = a[63:32] * b[63:32];
		run_op(op_mul_pair, a, b, r0, r1, status);
		check("status", 64'(status), 64'(done_word));
		check("r0_lo", 64'(r0[31:0]), 64'(exp_lo));
		check("r0_hi", 64'(r0[63:32]), 64'(exp_hi));
	endtask

	task automatic wide_case(input logic [63:0] a, input logic [63:0] b);
		logic [63:0] r0;
		logic [63:0] r1;
		logic [31:0] status;
		logic [63:0] exp;
		exp = a * b;
		run_op(op_mul_wide, a, b, r0, r1, status);
		check("status", 64'(status), 64'(done_word));
		check("r0", r0, exp);
	endtask

	task automatic udiv_case(input logic [63:0] a, input logic [63:0] b);
		logic [63:0] r0;
		logic [63:0] r1;
		logic [31:0] status;
		logic [63:0] exp_q;
		logic [63:0] exp_r;
		exp_q = a / b;
		exp_r = a % b;
		run_op(op_div_unsigned, a, b, r0, r1, status);
		check("status", 64'(status), 64'(done_word));
		check("quotient", r0, exp_q);
		check("remainder", r1, exp_r);
	endtask

	task automatic sdiv_case(input logic [63:0] a, input logic [63:0] b);
		logic [63:0]        r0;
		logic [63:0]        r1;
		logic [31:0]        status;
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic signed [63:0] exp_q;
		logic signed [63:0] exp_r;
		sa = a;
		sb = b;
		// truncates toward zero, remainder keeps the numerator's sign
		exp_q = sa / sb;
		exp_r = sa % sb;
		run_op(op_div_signed, a, b, r0, r1, status);
		check("status", 64'(status), 64'(done_word));
		check("signed quotient", r0, exp_q);
		check("signed remainder", r1, exp_r);
	endtask

	task automatic pair_multiply();
		logic [63:0] a;
		logic [63:0] b;
		for (int i = 0; i < 8; i++)
		begin
			a = rand64();
			b = rand64();
			pair_case(a, b);
		end
		pair_case(all_ones, all_ones);
		pair_case(64'h0000_FFFF_FFFF_0000, 64'hFFFF_0000_0000_FFFF);
	endtask

	task automatic wide_multiply();
		logic [63:0] a;
		logic [63:0] b;
		for (int i = 0; i < 8; i++)
		begin
			a = rand64();
			b = rand64();
			wide_case(a, b);
		end
		a = rand64();
		wide_case(64'h0, a);
		wide_case(a, 64'h0);
		wide_case(64'h1, a);
		wide_case(a, 64'h1);
		wide_case(all_ones, all_ones);
		wide_case(all_ones, a);
	endtask

	task automatic unsigned_divide();
		logic [63:0] a;
		logic [63:0] b;
		for (int i = 0; i < 6; i++)
		begin
			a = rand64();
			b = {32'h0, next_word()} | 64'h1;
			udiv_case(a, b);
		end
		a = rand64();
		b = rand64() | 64'h1;
		udiv_case(a, b);
		// numerator below the denominator
		udiv_case(64'h1234, 64'hFFFF_0000_0000_0000);
		udiv_case(a, a | 64'h1);
		udiv_case(all_ones, 64'h1);
		udiv_case(all_ones, all_ones);
	endtask

	task automatic signed_divide();
		logic [63:0] a;
		logic [63:0] b;
		for (int i = 0; i < 3; i++)
		begin
			a = rand64() >> 1;
			b = (rand64() >> 30) | 64'h1;
			sdiv_case(a, b);
			sdiv_case(-a, b);
			sdiv_case(a, -b);
			sdiv_case(-a, -b);
		end
		sdiv_case(-64'd7, 64'd2);
		sdiv_case(64'd7, -64'd2);
		sdiv_case(64'h8000_0000_0000_0000, 64'h1);
	endtask

	task automatic divide_by_zero();
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] r0;
		logic [63:0] r1;
		logic [31:0] status;
		a = rand64();
		run_op(op_div_unsigned, a, 64'h0, r0, r1, status);
		check("status after divide by zero", 64'(status), 64'(dbz_word));
		check("r0 after divide by zero", r0, all_ones);
		check("r1 after divide by zero", r1, a);
		a = rand64();
		run_op(op_div_signed, a, 64'h0, r0, r1, status);
		check("status after signed divide by zero", 64'(status), 64'(dbz_word));
		check("r0 after signed divide by zero", r0, all_ones);
		check("r1 after signed divide by zero", r1, a);
		// udiv_case expects done alone, so div_by_zero must be clear again
		a = rand64();
		b = {32'h0, next_word()} | 64'h1;
		udiv_case(a, b);
	endtask

	task automatic bus_rules();
		logic [1:0]  resp;
		logic [31:0] word;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] quot;
		logic [63:0] r0;
		logic [63:0] r1;
		logic [31:0] status;
		axi_read(8'h28, word, resp);
		check("rresp at offset 28", 64'(resp), 64'(resp_slverr));
		axi_read(8'hFC, word, resp);
		check("rresp at offset fc", 64'(resp), 64'(resp_slverr));

		// second command lands while the divider is still running
		a = rand64();
		b = {32'h0, next_word()} | 64'h1;
		quot = a / b;
		start_op(op_div_unsigned, a, b);
		read_reg(reg_status, word);
		check("status while dividing", 64'(word), 64'(busy_word));
		axi_write(reg_ctrl, ctrl_word(op_mul_wide), resp);
		check("bresp for ctrl write while busy", 64'(resp), 64'(resp_okay));
		read_reg(reg_ctrl, word);
		check("ctrl op while busy", 64'(word[ctrl_op_msb:ctrl_op_lsb]),
			64'(op_div_unsigned));
		wait_done(status);
		check("status after ignored command", 64'(status), 64'(done_word));
		read_results(r0, r1);
		check("quotient after ignored command", r0, quot);
		check("remainder after ignored command", r1, a % b);

		// read-only registers keep their contents
		axi_write(reg_status, 32'hFFFF_FFFF, resp);
		check("bresp for status write", 64'(resp), 64'(resp_slverr));
		read_reg(reg_status, word);
		check("status after rejected write", 64'(word), 64'(done_word));
		axi_write(reg_r0_lo, ~quot[31:0], resp);
		check("bresp for r0_lo write", 64'(resp), 64'(resp_slverr));
		read_reg(reg_r0_lo, word);
		check("r0_lo after rejected write", 64'(word), 64'(quot[31:0]));

		a = rand64();
		b = rand64();
		write_reg(reg_a_lo, a[31:0]);
		write_reg(reg_a_hi, a[63:32]);
		write_reg(reg_b_lo, b[31:0]);
		write_reg(reg_b_hi, b[63:32]);
		read_reg(reg_a_lo, word);
		check("a_lo readback", 64'(word), 64'(a[31:0]));
		read_reg(reg_a_hi, word);
		check("a_hi readback", 64'(word), 64'(a[63:32]));
		read_reg(reg_b_lo, word);
		check("b_lo readback", 64'(word), 64'(b[31:0]));
		read_reg(reg_b_hi, word);
		check("b_hi readback", 64'(word), 64'(b[63:32]));
	endtask

	initial
	begin
		logic [31:0] word;
		rst_n <= 1'b0;
		awaddr <= '0;
		awvalid <= 1'b0;
		wdata <= '0;
		wvalid <= 1'b0;
		bready <= 1'b0;
		araddr <= '0;
		arvalid <= 1'b0;
		rready <= 1'b0;
		rng_state = 32'h6b34_94d0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		@(negedge clk);
		check("awready after reset", 64'(awready), 64'h0);
		check("wready after reset", 64'(wready), 64'h0);
		check("arready after reset", 64'(arready), 64'h0);
		check("bvalid after reset", 64'(bvalid), 64'h0);
		check("rvalid after reset", 64'(rvalid), 64'h0);
		read_reg(reg_status, word);
		check("status after reset", 64'(word), 64'h0);

		pair_multiply();
		wide_multiply();
		unsigned_divide();
		signed_divide();
		divide_by_zero();
		bus_rules();

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule
